//--- sim.f
verilog/synth_mix_pkg.sv
verilog/midi_cc_decoder.sv
verilog/midi_ctrl_data.sv
verilog/osc_voice_mixer.sv
verilog/synth_mix_top.sv
sim/tb_synth_mix.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the synth mixer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_synth_mix -f sim.f -o tb_synth_mix
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_synth_mix > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sim/tb_synth_mix.sv
`timescale 1ns/1ps

module tb_synth_mix;
    import synth_mix_pkg::*;

    typedef struct packed {
        bank_t      bank;
        logic [6:0] adr;
        logic [7:0] val;
        logic [3:0] ch;
        logic       exp_wr;
    } stim_t;

    logic              reg_clk;
    logic              arst_n;
    logic              rx_valid;
    logic [7:0]        rx_byte;
    logic              rd;
    bank_t             rd_bank;
    logic [6:0]        rd_adr;
    logic signed [7:0] rd_data;
    logic              rd_valid;
    logic              sample_valid;
    sample_t           osc_sample [V_OSC];
    logic              out_valid;
    sample_t           left;
    sample_t           right;
    osc_params_t       osc_params [V_OSC];
    logic [7:0]        patch_name [16];

    logic [7:0] model [4][128];     // Register model, one byte per bank address
    sample_t    exp_left [$];
    sample_t    exp_right [$];
    int         exp_cycle [$];
    int         cycle_cnt = 0;

    // Channel starts at 0, written to 5, then omni
    stim_t stim_tbl [23] = '{
        '{BANK_OSC,  7'h12, 8'h55, 4'd0, 1'b1},   // Osc 1 level
        '{BANK_OSC,  7'h37, 8'h10, 4'd0, 1'b1},   // Osc 3 pan
        '{BANK_COM,  7'h01, 8'h7F, 4'd0, 1'b1},
        '{BANK_COM,  7'h10, 8'h41, 4'd0, 1'b1},   // Name start
        '{BANK_COM,  7'h1F, 8'h7A, 4'd0, 1'b1},   // Name end
        '{BANK_MAT1, 7'h25, 8'h33, 4'd0, 1'b1},
        '{BANK_MAT2, 7'h3F, 8'h7E, 4'd0, 1'b1},
        '{BANK_OSC,  7'h0C, 8'h11, 4'd0, 1'b1},   // Unmapped offset
        '{BANK_OSC,  7'h45, 8'h22, 4'd0, 1'b1},   // No osc 4
        '{BANK_COM,  7'h05, 8'h23, 4'd0, 1'b1},
        '{BANK_OSC,  7'h02, 8'h24, 4'd5, 1'b0},   // Wrong channel
        '{BANK_COM,  7'h02, 8'h05, 4'd0, 1'b1},   // Channel 5
        '{BANK_OSC,  7'h02, 8'h21, 4'd0, 1'b0},
        '{BANK_OSC,  7'h02, 8'h21, 4'd5, 1'b1},
        '{BANK_COM,  7'h02, 8'h10, 4'd5, 1'b1},   // Omni
        '{BANK_OSC,  7'h13, 8'h05, 4'd9, 1'b1},
        '{BANK_OSC,  7'h03, 8'h7F, 4'd15, 1'b1},
        '{BANK_OSC,  7'h02, 8'h7F, 4'd3, 1'b1},
        '{BANK_OSC,  7'h07, 8'h00, 4'd3, 1'b1},
        '{BANK_OSC,  7'h22, 8'h30, 4'd3, 1'b1},
        '{BANK_OSC,  7'h27, 8'h7F, 4'd3, 1'b1},
        '{BANK_OSC,  7'h32, 8'h60, 4'd3, 1'b1},
        '{BANK_COM,  7'h01, 8'h50, 4'd3, 1'b1}    // Mixer master volume
    };

    synth_mix_top UUT (
        .reg_clk      (reg_clk),
        .arst_n       (arst_n),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte),
        .rd           (rd),
        .rd_bank      (rd_bank),
        .rd_adr       (rd_adr),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .sample_valid (sample_valid),
        .osc_sample   (osc_sample),
        .out_valid    (out_valid),
        .left         (left),
        .right        (right),
        .osc_params   (osc_params),
        .patch_name   (patch_name)
    );

    initial begin
        reg_clk = 1'b0;
        forever #10 reg_clk = ~reg_clk;
    end

    always @(posedge reg_clk) cycle_cnt <= cycle_cnt + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_byte(input string name, input logic signed [7:0] got,
                              input logic signed [7:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_params(input string name, input osc_params_t got,
                                input osc_params_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "parameter mismatch");
        end
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "sample mismatch");
        end
    endtask

    function automatic bit is_mapped(input bank_t b, input logic [6:0] a);
        case (b)
            BANK_OSC: return (a[6:4] < V_OSC) && (a[3:0] inside {OFS_LVL, OFS_MOD_OUT,
                             OFS_FEEDB_OUT, OFS_PAN, OFS_MOD_IN, OFS_FEEDB_IN});
            BANK_COM: return (a == ADR_MVOL) || (a == ADR_MIDI_CH) || (a >= 16 && a < 32);
            default:  return a[6:4] < V_OSC;
        endcase
    endfunction

    task automatic model_reset();
        for (int b = 0; b < 4; b++) begin
            for (int a = 0; a < 128; a++) begin
                model[b][a] = 8'h00;
            end
        end
        for (int i = 0; i < V_OSC; i++) begin
            model[BANK_OSC][i*16 + OFS_LVL] = (i < 2) ? 8'h40 : 8'h00;
            model[BANK_OSC][i*16 + OFS_PAN] = 8'h40;
        end
        model[BANK_COM][ADR_MVOL] = 8'h40;
        for (int s = 16; s < 32; s++) begin
            model[BANK_COM][s] = 8'd32;
        end
    endtask

    task automatic model_write(input bank_t b, input logic [6:0] a, input logic [7:0] v);
        if (is_mapped(b, a)) begin
            model[b][a] = (b == BANK_COM && a == ADR_MIDI_CH) ? (v & 8'h1F) : v;
        end
    endtask

    function automatic osc_params_t expected_params(input int i);
        osc_params_t p;
        p.lvl       = model[BANK_OSC][i*16 + OFS_LVL];
        p.mod_out   = model[BANK_OSC][i*16 + OFS_MOD_OUT];
        p.feedb_out = model[BANK_OSC][i*16 + OFS_FEEDB_OUT];
        p.pan       = model[BANK_OSC][i*16 + OFS_PAN];
        p.mod_in    = model[BANK_OSC][i*16 + OFS_MOD_IN];
        p.feedb_in  = model[BANK_OSC][i*16 + OFS_FEEDB_IN];
        return p;
    endfunction

    // Level, pan and volume as 0..127, >>> 13 then volume >>> 6 and clip
    function automatic sample_t mix_expect(input sample_t smp [V_OSC], input bit right_side);
        longint acc;
        longint lv;
        longint pn;
        longint vol;
        acc = 0;
        for (int i = 0; i < V_OSC; i++) begin
            lv  = model[BANK_OSC][i*16 + OFS_LVL] & 8'h7F;
            pn  = model[BANK_OSC][i*16 + OFS_PAN] & 8'h7F;
            acc = acc + longint'(smp[i]) * lv * (right_side ? pn : 127 - pn);
        end
        vol = model[BANK_COM][ADR_MVOL] & 8'h7F;
        acc = ((acc >>> 13) * vol) >>> 6;
        if (acc > 32767)
            return 16'sh7FFF;
        if (acc < -32768)
            return 16'sh8000;
        return sample_t'(acc);
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(posedge reg_clk);
        #2;
        rx_valid = 1'b1;
        rx_byte  = b;
        @(posedge reg_clk);
        #2;
        rx_valid = 1'b0;
    endtask

    // One status byte, then three CC pairs under running status
    task automatic send_nrpn(input stim_t st);
        send_byte({MIDI_STATUS_CC, st.ch});
        send_byte({1'b0, CC_NRPN_MSB});
        send_byte({6'd0, st.bank});
        send_byte({1'b0, CC_NRPN_LSB});
        send_byte({1'b0, st.adr});
        send_byte({1'b0, CC_DATA_ENTRY});
        send_byte(st.val);
        check_flag("write", UUT.write, st.exp_wr);
        @(posedge reg_clk);
        #2;
        check_flag("write", UUT.write, 1'b0);   // Single-cycle strobe
    endtask

    task automatic read_check(input bank_t b, input logic [6:0] a);
        int                waited;
        logic signed [7:0] exp;
        @(posedge reg_clk);
        #2;
        rd      = 1'b1;
        rd_bank = b;
        rd_adr  = a;
        @(posedge reg_clk);
        #2;
        rd     = 1'b0;
        waited = 0;
        while (rd_valid !== 1'b1) begin
            if (waited >= 8)
                abort_run("Register readback never returned rd_valid");
            @(posedge reg_clk);
            #2;
            waited++;
        end
        if (waited != 0)
            abort_run($sformatf("Readback took %0d extra cycles", waited));
        exp = is_mapped(b, a) ? model[b][a] : 8'sd0;
        check_byte($sformatf("rd_data %s[%0d]", b.name(), a), rd_data, exp);
    endtask

    task automatic sweep_all();
        for (int b = 0; b < 4; b++) begin
            for (int a = 0; a < 128; a++) begin
                read_check(bank_t'(b), 7'(a));
            end
        end
        for (int i = 0; i < V_OSC; i++) begin
            check_params($sformatf("osc_params[%0d]", i), osc_params[i], expected_params(i));
        end
        for (int s = 0; s < 16; s++) begin
            check_byte($sformatf("patch_name[%0d]", s), patch_name[s],
                       model[BANK_COM][ADR_NAME_BASE + s]);
        end
    endtask

    task automatic running_status_test();
        send_byte(8'hB3);
        send_byte({1'b0, CC_NRPN_MSB});
        send_byte(8'hF8);                       // Clock tick mid-message
        send_byte(8'h00);
        send_byte({1'b0, CC_NRPN_LSB});
        send_byte(8'hF8);
        send_byte(8'h1B);                       // Osc 1 feedb_in
        send_byte({1'b0, CC_DATA_ENTRY});
        send_byte(8'hF8);
        send_byte(8'h2C);
        check_flag("write", UUT.write, 1'b1);
        model_write(BANK_OSC, 7'h1B, 8'h2C);
        read_check(BANK_OSC, 7'h1B);
        send_byte(8'hF0);                       // SysEx start drops running status
        send_byte({1'b0, CC_DATA_ENTRY});
        send_byte(8'h11);
        check_flag("write", UUT.write, 1'b0);
        read_check(BANK_OSC, 7'h1B);
        send_byte(8'hB7);
        send_byte({1'b0, CC_DATA_ENTRY});
        send_byte(8'h12);
        check_flag("write", UUT.write, 1'b1);
        model_write(BANK_OSC, 7'h1B, 8'h12);
        read_check(BANK_OSC, 7'h1B);
    endtask

    task automatic drive_sample(input sample_t smp [V_OSC]);
        @(posedge reg_clk);
        #2;
        osc_sample   = smp;
        sample_valid = 1'b1;
        exp_left.push_back(mix_expect(smp, 1'b0));
        exp_right.push_back(mix_expect(smp, 1'b1));
        exp_cycle.push_back(cycle_cnt);
    endtask

    task automatic mixer_test();
        sample_t smp [V_OSC];
        for (int n = 0; n < 24; n++) begin
            for (int i = 0; i < V_OSC; i++) begin
                smp[i] = sample_t'($urandom) >>> ((n % 2 == 0) ? 0 : 5);
            end
            drive_sample(smp);                  // Back to back
        end
        @(posedge reg_clk);
        #2;
        sample_valid = 1'b0;
        smp = '{default: 16'sh7FFF};
        drive_sample(smp);
        smp = '{default: 16'sh8000};
        drive_sample(smp);
        smp = '{default: 16'sh0000};
        drive_sample(smp);
        @(posedge reg_clk);
        #2;
        sample_valid = 1'b0;
    endtask

    always @(negedge reg_clk) begin : out_monitor
        int sent;
        if (arst_n === 1'b1 && out_valid === 1'b1) begin
            if (exp_left.size() == 0)
                abort_run("Mixer raised out_valid with no sample pending");
            sent = exp_cycle.pop_front();
            if (cycle_cnt - sent != 2)
                abort_run($sformatf("Mixer latency was %0d cycles", cycle_cnt - sent));
            check_sample("left", left, exp_left.pop_front());
            check_sample("right", right, exp_right.pop_front());
        end
    end

    initial begin
        int waited;
        void'($urandom(32'he610_7f05));
        arst_n       = 1'b0;
        rx_valid     = 1'b0;
        rx_byte      = 8'h00;
        rd           = 1'b0;
        rd_bank      = BANK_OSC;
        rd_adr       = 7'd0;
        sample_valid = 1'b0;
        osc_sample   = '{default: 16'sh0000};
        model_reset();
        repeat (5) @(posedge reg_clk);
        #2;
        arst_n = 1'b1;
        check_flag("write", UUT.write, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        sweep_all();

        foreach (stim_tbl[k]) begin
            send_nrpn(stim_tbl[k]);
            if (stim_tbl[k].exp_wr)
                model_write(stim_tbl[k].bank, stim_tbl[k].adr, stim_tbl[k].val);
            read_check(stim_tbl[k].bank, stim_tbl[k].adr);
        end
        sweep_all();                            // Nothing else moved

        running_status_test();
        mixer_test();

        waited = 0;
        while (exp_left.size() != 0) begin
            if (waited >= 10)
                abort_run("Mixer results still missing after the last sample");
            @(posedge reg_clk);
            #2;
            waited++;
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- verilog/synth_mix_top.sv
`timescale 1ns/1ps

module synth_mix_top (
    input  logic                        reg_clk,
    input  logic                        arst_n,
    input  logic                        rx_valid,
    input  logic [7:0]                  rx_byte,
    input  logic                        rd,
    input  synth_mix_pkg::bank_t        rd_bank,
    input  logic [6:0]                  rd_adr,
    output logic signed [7:0]           rd_data,
    output logic                        rd_valid,
    input  logic                        sample_valid,
    input  synth_mix_pkg::sample_t      osc_sample [synth_mix_pkg::V_OSC],
    output logic                        out_valid,
    output synth_mix_pkg::sample_t      left,
    output synth_mix_pkg::sample_t      right,
    output synth_mix_pkg::osc_params_t  osc_params [synth_mix_pkg::V_OSC],
    output logic [7:0]                  patch_name [16]
);
    import synth_mix_pkg::*;

    reg_cmd_t          cmd;
    logic              write;
    logic [4:0]        cur_midi_ch;
    logic signed [7:0] m_vol;

    midi_cc_decoder u_decoder (
        .reg_clk     (reg_clk),
        .arst_n      (arst_n),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .cur_midi_ch (cur_midi_ch),
        .write       (write),
        .cmd         (cmd)
    );

    // Matrix buffers only reach the host through readback
    midi_ctrl_data u_regs (
        .reg_clk     (reg_clk),
        .arst_n      (arst_n),
        .write       (write),
        .cmd         (cmd),
        .rd          (rd),
        .rd_bank     (rd_bank),
        .rd_adr      (rd_adr),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .osc_params  (osc_params),
        .m_vol       (m_vol),
        .cur_midi_ch (cur_midi_ch),
        .patch_name  (patch_name),
        .mat_buf1    (),
        .mat_buf2    ()
    );

    osc_voice_mixer u_mixer (
        .reg_clk      (reg_clk),
        .arst_n       (arst_n),
        .sample_valid (sample_valid),
        .osc_sample   (osc_sample),
        .osc_params   (osc_params),
        .m_vol        (m_vol),
        .out_valid    (out_valid),
        .left         (left),
        .right        (right)
    );

endmodule

//--- verilog/osc_voice_mixer.sv
`timescale 1ns/1ps

module osc_voice_mixer (
    input  logic                        reg_clk,
    input  logic                        arst_n,
    input  logic                        sample_valid,
    input  synth_mix_pkg::sample_t      osc_sample [synth_mix_pkg::V_OSC],
    input  synth_mix_pkg::osc_params_t  osc_params [synth_mix_pkg::V_OSC],
    input  logic signed [7:0]           m_vol,
    output logic                        out_valid,
    output synth_mix_pkg::sample_t      left,
    output synth_mix_pkg::sample_t      right
);
    import synth_mix_pkg::*;

    logic signed [23:0] prod [V_OSC];
    logic signed [33:0] sum_l;
    logic signed [33:0] sum_r;
    logic               s1_valid;
    logic signed [20:0] s1_left;
    logic signed [20:0] s1_right;
    logic signed [28:0] vol_l;
    logic signed [28:0] vol_r;
    sample_t            sat_l;
    sample_t            sat_r;

    function automatic sample_t saturate(input logic signed [22:0] v);
        if (v > 23'sd32767)
            return 16'sh7FFF;
        else if (v < -23'sd32768)
            return 16'sh8000;
        return v[15:0];
    endfunction

    // Level and pan taken as 0..127
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < V_OSC; i++) begin
            prod[i] = osc_sample[i] * $signed({1'b0, osc_params[i].lvl[6:0]});
            sum_l   = sum_l + prod[i] * $signed({1'b0, 7'd127 - osc_params[i].pan[6:0]});
            sum_r   = sum_r + prod[i] * $signed({1'b0, osc_params[i].pan[6:0]});
        end
    end

    assign vol_l = s1_left * $signed({1'b0, m_vol[6:0]});
    assign vol_r = s1_right * $signed({1'b0, m_vol[6:0]});
    assign sat_l = saturate(vol_l[28:6]);   // >>> 6
    assign sat_r = saturate(vol_r[28:6]);

    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= sample_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (sample_valid) begin
            s1_left  <= sum_l[33:13];   // Arithmetic >>> 13
            s1_right <= sum_r[33:13];
        end
        if (s1_valid) begin
            left  <= sat_l;
            right <= sat_r;
        end
    end

    // Fixed two-cycle latency, no stall
    assert property (@(posedge reg_clk) disable iff (!arst_n)
        out_valid == $past(sample_valid, 2))
        else $error("mixer valid pipeline out of step");

endmodule

//--- verilog/midi_ctrl_data.sv
`timescale 1ns/1ps

module midi_ctrl_data (
    input  logic                        reg_clk,
    input  logic                        arst_n,
    input  logic                        write,
    input  synth_mix_pkg::reg_cmd_t     cmd,
    input  logic                        rd,
    input  synth_mix_pkg::bank_t        rd_bank,
    input  logic [6:0]                  rd_adr,
    output logic signed [7:0]           rd_data,
    output logic                        rd_valid,
    output synth_mix_pkg::osc_params_t  osc_params [synth_mix_pkg::V_OSC],
    output logic signed [7:0]           m_vol,
    output logic [4:0]                  cur_midi_ch,
    output logic [7:0]                  patch_name [16],
    output logic signed [7:0]           mat_buf1 [16][synth_mix_pkg::V_OSC],
    output logic signed [7:0]           mat_buf2 [16][synth_mix_pkg::V_OSC]
);
    import synth_mix_pkg::*;

    logic signed [7:0] rd_mux;
    logic              name_wr;
    logic              name_rd;

    assign name_wr = (cmd.adr >= ADR_NAME_BASE) && (cmd.adr < ADR_NAME_BASE + 7'd16);
    assign name_rd = (rd_adr >= ADR_NAME_BASE) && (rd_adr < ADR_NAME_BASE + 7'd16);

    // Banked write, upper address bits pick the oscillator
    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < V_OSC; i++) begin
                osc_params[i].lvl       <= LVL_RESET[i];
                osc_params[i].mod_out   <= '0;
                osc_params[i].feedb_out <= '0;
                osc_params[i].pan       <= PAN_RESET;
                osc_params[i].mod_in    <= '0;
                osc_params[i].feedb_in  <= '0;
            end
            for (int s = 0; s < 16; s++) begin
                patch_name[s] <= NAME_RESET;
                for (int i = 0; i < V_OSC; i++) begin
                    mat_buf1[s][i] <= '0;
                    mat_buf2[s][i] <= '0;
                end
            end
            m_vol       <= MVOL_RESET;
            cur_midi_ch <= '0;
        end else if (write) begin
            case (cmd.bank)
                BANK_OSC: begin
                    for (int i = 0; i < V_OSC; i++) begin
                        if (cmd.adr[6:4] == i) begin
                            case (cmd.adr[3:0])
                                OFS_LVL:       osc_params[i].lvl       <= cmd.data;
                                OFS_MOD_OUT:   osc_params[i].mod_out   <= cmd.data;
                                OFS_FEEDB_OUT: osc_params[i].feedb_out <= cmd.data;
                                OFS_PAN:       osc_params[i].pan       <= cmd.data;
                                OFS_MOD_IN:    osc_params[i].mod_in    <= cmd.data;
                                OFS_FEEDB_IN:  osc_params[i].feedb_in  <= cmd.data;
                                default: ;
                            endcase
                        end
                    end
                end
                BANK_COM: begin
                    if (cmd.adr == ADR_MVOL) begin
                        m_vol <= cmd.data;
                    end else if (cmd.adr == ADR_MIDI_CH) begin
                        cur_midi_ch <= cmd.data[4:0];   // Bit 4 is omni
                    end else if (name_wr) begin
                        patch_name[cmd.adr[3:0]] <= cmd.data;
                    end
                end
                BANK_MAT1: begin
                    for (int i = 0; i < V_OSC; i++) begin
                        if (cmd.adr[6:4] == i) begin
                            mat_buf1[cmd.adr[3:0]][i] <= cmd.data;
                        end
                    end
                end
                BANK_MAT2: begin
                    for (int i = 0; i < V_OSC; i++) begin
                        if (cmd.adr[6:4] == i) begin
                            mat_buf2[cmd.adr[3:0]][i] <= cmd.data;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Readback select, unmapped addresses give 0
    always_comb begin
        rd_mux = '0;
        case (rd_bank)
            BANK_OSC: begin
                for (int i = 0; i < V_OSC; i++) begin
                    if (rd_adr[6:4] == i) begin
                        case (rd_adr[3:0])
                            OFS_LVL:       rd_mux = osc_params[i].lvl;
                            OFS_MOD_OUT:   rd_mux = osc_params[i].mod_out;
                            OFS_FEEDB_OUT: rd_mux = osc_params[i].feedb_out;
                            OFS_PAN:       rd_mux = osc_params[i].pan;
                            OFS_MOD_IN:    rd_mux = osc_params[i].mod_in;
                            OFS_FEEDB_IN:  rd_mux = osc_params[i].feedb_in;
                            default: ;
                        endcase
                    end
                end
            end
            BANK_COM: begin
                if (rd_adr == ADR_MVOL) begin
                    rd_mux = m_vol;
                end else if (rd_adr == ADR_MIDI_CH) begin
                    rd_mux = {3'b000, cur_midi_ch};
                end else if (name_rd) begin
                    rd_mux = patch_name[rd_adr[3:0]];
                end
            end
            BANK_MAT1: begin
                for (int i = 0; i < V_OSC; i++) begin
                    if (rd_adr[6:4] == i) begin
                        rd_mux = mat_buf1[rd_adr[3:0]][i];
                    end
                end
            end
            BANK_MAT2: begin
                for (int i = 0; i < V_OSC; i++) begin
                    if (rd_adr[6:4] == i) begin
                        rd_mux = mat_buf2[rd_adr[3:0]][i];
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rd) begin
            rd_data <= rd_mux;      // Held until next read
        end
    end

    // Strobes from decoder and host must be clean once out of reset
    assert property (@(posedge reg_clk) disable iff (!arst_n) !$isunknown({write, rd}))
        else $error("register bank strobe unknown");

endmodule

//--- verilog/midi_cc_decoder.sv
`timescale 1ns/1ps

module midi_cc_decoder (
    input  logic                    reg_clk,
    input  logic                    arst_n,
    input  logic                    rx_valid,
    input  logic [7:0]              rx_byte,
    input  logic [4:0]              cur_midi_ch,
    output logic                    write,
    output synth_mix_pkg::reg_cmd_t cmd
);
    import synth_mix_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CTRL_NUM,
        ST_CTRL_VAL
    } state_t;

    state_t     state;
    logic [6:0] ctrl_num;
    bank_t      nrpn_bank;
    logic [6:0] nrpn_adr;
    logic       is_realtime;
    logic       is_system;
    logic       is_status;
    logic       is_data;
    logic       ch_match;
    logic       cc_accept;
    logic       data_entry;

    assign is_realtime = rx_valid && (rx_byte >= 8'hF8);
    assign is_system   = rx_valid && (rx_byte[7:4] == 4'hF) && !is_realtime;
    assign is_status   = rx_valid && rx_byte[7] && (rx_byte[7:4] != 4'hF);
    assign is_data     = rx_valid && !rx_byte[7];

    // Omni bit opens every channel
    assign ch_match  = cur_midi_ch[4] || (rx_byte[3:0] == cur_midi_ch[3:0]);
    assign cc_accept = (rx_byte[7:4] == MIDI_STATUS_CC) && ch_match;

    assign data_entry = is_data && (state == ST_CTRL_VAL) && (ctrl_num == CC_DATA_ENTRY);

    // State holds the running status, ST_IDLE drops data bytes
    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            ctrl_num  <= '0;
            nrpn_bank <= BANK_OSC;
            nrpn_adr  <= '0;
            write     <= 1'b0;
        end else begin
            write <= data_entry;
            if (is_status) begin
                state <= cc_accept ? ST_CTRL_NUM : ST_IDLE;
            end else if (is_system) begin
                state <= ST_IDLE;               // SysEx and common msgs cancel
            end else if (is_data) begin
                case (state)
                    ST_CTRL_NUM: begin
                        ctrl_num <= rx_byte[6:0];
                        state    <= ST_CTRL_VAL;
                    end
                    ST_CTRL_VAL: begin
                        case (ctrl_num)
                            CC_NRPN_MSB: nrpn_bank <= bank_t'(rx_byte[1:0]);
                            CC_NRPN_LSB: nrpn_adr  <= rx_byte[6:0];
                            default: ;
                        endcase
                        state <= ST_CTRL_NUM;   // Next pair under same status
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (data_entry) begin
            cmd.bank <= nrpn_bank;
            cmd.adr  <= nrpn_adr;
            cmd.data <= {1'b0, rx_byte[6:0]};
        end
    end

    // One register write per data-entry value byte
    assert property (@(posedge reg_clk) disable iff (!arst_n) write |=> !write)
        else $error("decoder write strobe longer than one cycle");

endmodule

//--- verilog/synth_mix_pkg.sv
package synth_mix_pkg;

    // Oscillators per voice, one per 16 addresses in a 7-bit map
    localparam int V_OSC = 4;

    typedef enum logic [1:0] {
        BANK_OSC  = 2'd0,
        BANK_COM  = 2'd1,
        BANK_MAT1 = 2'd2,
        BANK_MAT2 = 2'd3
    } bank_t;

    // Register write command from the MIDI decoder
    typedef struct packed {
        bank_t              bank;
        logic [6:0]         adr;
        logic signed [7:0]  data;
    } reg_cmd_t;

    typedef struct packed {
        logic signed [7:0]  lvl;
        logic signed [7:0]  mod_out;
        logic signed [7:0]  feedb_out;
        logic signed [7:0]  pan;
        logic signed [7:0]  mod_in;
        logic signed [7:0]  feedb_in;
    } osc_params_t;

    typedef logic signed [15:0] sample_t;

    // Oscillator bank, offset within each 16-address block
    localparam logic [3:0] OFS_LVL       = 4'd2;
    localparam logic [3:0] OFS_MOD_OUT   = 4'd3;
    localparam logic [3:0] OFS_FEEDB_OUT = 4'd4;
    localparam logic [3:0] OFS_PAN       = 4'd7;
    localparam logic [3:0] OFS_MOD_IN    = 4'd10;
    localparam logic [3:0] OFS_FEEDB_IN  = 4'd11;

    // Common bank
    localparam logic [6:0] ADR_MVOL      = 7'd1;
    localparam logic [6:0] ADR_MIDI_CH   = 7'd2;
    localparam logic [6:0] ADR_NAME_BASE = 7'd16;

    localparam logic [6:0] CC_NRPN_MSB    = 7'd99;
    localparam logic [6:0] CC_NRPN_LSB    = 7'd98;
    localparam logic [6:0] CC_DATA_ENTRY  = 7'd6;
    localparam logic [3:0] MIDI_STATUS_CC = 4'hB;

    // Power-up values, oscillators 0 and 1 audible
    localparam logic [V_OSC-1:0][7:0] LVL_RESET = {8'h00, 8'h00, 8'h40, 8'h40};
    localparam logic [7:0] PAN_RESET  = 8'h40;   // Centre
    localparam logic [7:0] MVOL_RESET = 8'h40;
    localparam logic [7:0] NAME_RESET = 8'd32;   // ASCII space

endpackage
